/* design/vrf_pkg.sv */
/*
 * Vector register file package: geometry constants,
 * address, data and byte-enable types, and the write-stage request struct
 */

package vrf_pkg;

  // Architectural view
  localparam int unsigned NR_VREGS = 32;
  localparam int unsigned VLEN     = 256;

  // Storage organization
  localparam int unsigned ROWS_PER_VREG = 2;
  localparam int unsigned NR_BANKS      = 4;
  localparam int unsigned NR_ROWS       = NR_VREGS * ROWS_PER_VREG;
  localparam int unsigned ROW_WIDTH     = VLEN / ROWS_PER_VREG;
  localparam int unsigned ELEM_WIDTH    = ROW_WIDTH / NR_BANKS;

  // Byte granularity of rows and lanes
  localparam int unsigned ROW_BYTES  = ROW_WIDTH / 8;
  localparam int unsigned ELEM_BYTES = ELEM_WIDTH / 8;

  // Row address width, register number above the half bit
  localparam int unsigned ROW_ADDR_WIDTH = $clog2(NR_ROWS);

  // Port counts
  localparam int unsigned NR_WRITE_PORTS = 2;
  localparam int unsigned NR_READ_PORTS  = 3;

  // Row address {vreg, half}
  typedef logic [ROW_ADDR_WIDTH-1:0] vreg_addr_t;

  // One full port word
  typedef logic [ROW_WIDTH-1:0] vreg_data_t;

  // Byte enables of a port word
  typedef logic [ROW_BYTES-1:0] vreg_be_t;

  // One bank lane within a row
  typedef logic [ELEM_WIDTH-1:0] lane_data_t;

  // Byte enables of one lane
  typedef logic [ELEM_BYTES-1:0] lane_be_t;

  // One-hot row select, one bit per row
  typedef logic [NR_ROWS-1:0] row_onehot_t;

  // Sampled write request, committed one cycle after capture
  typedef struct packed {
    logic       valid;
    vreg_addr_t row;
    vreg_data_t data;
    vreg_be_t   be;
  } vrf_wreq_t;

endpackage : vrf_pkg

/* design/vrf_write_stage.sv */
/*
 * Write stage of the vector register file
 * Registers each write port request and decodes its row to a one-hot select
 */

module vrf_write_stage (
  input  logic                                                clk,
  input  logic                                                rst_ni,
  // Incoming write requests
  input  vrf_pkg::vreg_addr_t  [vrf_pkg::NR_WRITE_PORTS-1:0] waddr_i,
  input  vrf_pkg::vreg_data_t  [vrf_pkg::NR_WRITE_PORTS-1:0] wdata_i,
  input  logic                 [vrf_pkg::NR_WRITE_PORTS-1:0] we_i,
  input  vrf_pkg::vreg_be_t    [vrf_pkg::NR_WRITE_PORTS-1:0] wbe_i,
  // Registered requests towards the banks
  output vrf_pkg::vrf_wreq_t   [vrf_pkg::NR_WRITE_PORTS-1:0] wreq_o,
  output vrf_pkg::row_onehot_t [vrf_pkg::NR_WRITE_PORTS-1:0] row_hit_o
);

  import vrf_pkg::*;

  logic       [NR_WRITE_PORTS-1:0] valid_q;
  vreg_addr_t [NR_WRITE_PORTS-1:0] row_q;
  vreg_data_t [NR_WRITE_PORTS-1:0] data_q;
  vreg_be_t   [NR_WRITE_PORTS-1:0] be_q;

  // Valid bits follow the strobes
  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= we_i;
    end
  end

  // Payload only loads on an accepted write
  always_ff @(posedge clk) begin
    for (int p = 0; p < NR_WRITE_PORTS; p++) begin
      if (we_i[p]) begin
        row_q[p]  <= waddr_i[p];
        data_q[p] <= wdata_i[p];
        be_q[p]   <= wbe_i[p];
      end
    end
  end

  for (genvar p = 0; p < NR_WRITE_PORTS; p++) begin : gen_port
    // Pack the sampled fields into the request struct
    assign wreq_o[p] = '{
      valid: valid_q[p],
      row:   row_q[p],
      data:  data_q[p],
      be:    be_q[p]
    };

    // One-hot row select, all zero for an idle port
    assign row_hit_o[p] = valid_q[p] ? (row_onehot_t'(1) << row_q[p]) : '0;
  end

endmodule : vrf_write_stage

/* design/vrf_bank.sv */
/*
 * One lane bank of the vector register file
 * Byte-wise priority merge of the write ports, flip-flop storage
 * and combinational read muxes
 */

module vrf_bank (
  input  logic                                                clk,
  input  logic                                                rst_ni,
  // Write side, already decoded per row
  input  vrf_pkg::row_onehot_t [vrf_pkg::NR_WRITE_PORTS-1:0] row_hit_i,
  input  vrf_pkg::lane_data_t  [vrf_pkg::NR_WRITE_PORTS-1:0] wdata_i,
  input  vrf_pkg::lane_be_t    [vrf_pkg::NR_WRITE_PORTS-1:0] wbe_i,
  // Read side
  input  vrf_pkg::vreg_addr_t  [vrf_pkg::NR_READ_PORTS-1:0]  raddr_i,
  output vrf_pkg::lane_data_t  [vrf_pkg::NR_READ_PORTS-1:0]  rdata_o
);

  import vrf_pkg::*;

  // Lane word of every row
  lane_data_t [NR_ROWS-1:0] mem_q;

  // Merged write data and per-byte enables
  lane_data_t [NR_ROWS-1:0]                 mem_d;
  logic       [NR_ROWS-1:0][ELEM_BYTES-1:0] byte_we;

  // Ports are scanned upwards so the highest hitting port wins a byte
  always_comb begin
    mem_d   = '0;
    byte_we = '0;
    for (int r = 0; r < NR_ROWS; r++) begin
      for (int b = 0; b < ELEM_BYTES; b++) begin
        for (int p = 0; p < NR_WRITE_PORTS; p++) begin
          if (row_hit_i[p][r] && wbe_i[p][b]) begin
            mem_d[r][8*b +: 8] = wdata_i[p][8*b +: 8];
            byte_we[r][b]      = 1'b1;
          end
        end
      end
    end
  end

  // Storage, only enabled bytes are updated
  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int b = 0; b < ELEM_BYTES; b++) begin
          if (byte_we[r][b]) begin
            mem_q[r][8*b +: 8] <= mem_d[r][8*b +: 8];
          end
        end
      end
    end
  end

  // Read muxes
  for (genvar p = 0; p < NR_READ_PORTS; p++) begin : gen_read
    assign rdata_o[p] = mem_q[raddr_i[p]];
  end

endmodule : vrf_bank

/* design/vector_regfile.sv */
/*
 * Top level of the banked vector register file
 * Write stage, four lane banks, lane slicing and valid strobes
 */

module vector_regfile (
  input  logic                                               clk,
  input  logic                                               rst_ni,
  // Write ports
  input  vrf_pkg::vreg_addr_t [vrf_pkg::NR_WRITE_PORTS-1:0] waddr_i,
  input  vrf_pkg::vreg_data_t [vrf_pkg::NR_WRITE_PORTS-1:0] wdata_i,
  input  logic                [vrf_pkg::NR_WRITE_PORTS-1:0] we_i,
  input  vrf_pkg::vreg_be_t   [vrf_pkg::NR_WRITE_PORTS-1:0] wbe_i,
  output logic                [vrf_pkg::NR_WRITE_PORTS-1:0] wvalid_o,
  // Read ports
  input  vrf_pkg::vreg_addr_t [vrf_pkg::NR_READ_PORTS-1:0]  raddr_i,
  input  logic                [vrf_pkg::NR_READ_PORTS-1:0]  re_i,
  output vrf_pkg::vreg_data_t [vrf_pkg::NR_READ_PORTS-1:0]  rdata_o,
  output logic                [vrf_pkg::NR_READ_PORTS-1:0]  rvalid_o
);

  import vrf_pkg::*;

  // Registered write requests
  vrf_wreq_t   [NR_WRITE_PORTS-1:0] wreq;
  row_onehot_t [NR_WRITE_PORTS-1:0] row_hit;

  // Per-bank lane views of the write and read data
  lane_data_t [NR_BANKS-1:0][NR_WRITE_PORTS-1:0] lane_wdata;
  lane_be_t   [NR_BANKS-1:0][NR_WRITE_PORTS-1:0] lane_wbe;
  lane_data_t [NR_BANKS-1:0][NR_READ_PORTS-1:0]  lane_rdata;

  // No back-pressure, so the valids mirror the request strobes
  assign wvalid_o = we_i;
  assign rvalid_o = re_i;

  vrf_write_stage u_write_stage (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .waddr_i  (waddr_i),
    .wdata_i  (wdata_i),
    .we_i     (we_i),
    .wbe_i    (wbe_i),
    .wreq_o   (wreq),
    .row_hit_o(row_hit)
  );

  for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank
    // Bank b owns lane b of every row
    for (genvar p = 0; p < NR_WRITE_PORTS; p++) begin : gen_wslice
      assign lane_wdata[b][p] = wreq[p].data[ELEM_WIDTH*b +: ELEM_WIDTH];
      assign lane_wbe[b][p]   = wreq[p].be[ELEM_BYTES*b +: ELEM_BYTES];
    end

    vrf_bank u_bank (
      .clk      (clk),
      .rst_ni   (rst_ni),
      .row_hit_i(row_hit),
      .wdata_i  (lane_wdata[b]),
      .wbe_i    (lane_wbe[b]),
      .raddr_i  (raddr_i),
      .rdata_o  (lane_rdata[b])
    );

    // Bank 0 lands in the least significant lane
    for (genvar p = 0; p < NR_READ_PORTS; p++) begin : gen_rslice
      assign rdata_o[p][ELEM_WIDTH*b +: ELEM_WIDTH] = lane_rdata[b][p];
    end
  end

endmodule : vector_regfile

/* dv/vector_regfile_checker.sv */
/*
 * Concurrent assertions on the vector register file ports
 * Valid strobes and known read data, bound into the top level
 */

module vector_regfile_checker (
  input logic                                               clk,
  input logic                                               rst_ni,
  input logic                [vrf_pkg::NR_WRITE_PORTS-1:0] we_i,
  input logic                [vrf_pkg::NR_WRITE_PORTS-1:0] wvalid_o,
  input logic                [vrf_pkg::NR_READ_PORTS-1:0]  re_i,
  input logic                [vrf_pkg::NR_READ_PORTS-1:0]  rvalid_o,
  input vrf_pkg::vreg_data_t [vrf_pkg::NR_READ_PORTS-1:0]  rdata_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import vrf_pkg::*;

  // No back-pressure, valids are plain copies of the strobes
  a_wvalid_follows_we: assert property (@(posedge clk) wvalid_o == we_i)
    else $error("wvalid_o differs from we_i");

  a_rvalid_follows_re: assert property (@(posedge clk) rvalid_o == re_i)
    else $error("rvalid_o differs from re_i");

  for (genvar p = 0; p < NR_READ_PORTS; p++) begin : gen_rdata
    a_rdata_known: assert property (
      @(posedge clk) disable iff (!rst_ni) re_i[p] |-> !$isunknown(rdata_o[p]))
      else $error("rdata_o[%0d] has unknown bits during a read", p);
  end

endmodule : vector_regfile_checker

bind vector_regfile vector_regfile_checker u_checker (
  .clk     (clk),
  .rst_ni  (rst_ni),
  .we_i    (we_i),
  .wvalid_o(wvalid_o),
  .re_i    (re_i),
  .rvalid_o(rvalid_o),
  .rdata_o (rdata_o)
);

/* dv/tb_vector_regfile.sv */
/*
 * Testbench for the vector register file
 * Clock, reset, stimulus table, storage reference model, compare task, timeout
 */

module tb_vector_regfile;

  timeunit 1ns;
  timeprecision 100ps;

  import vrf_pkg::*;

  localparam int RESET_CYCLES = 4;

  // One table row, write ports and read ports of a single cycle
  typedef struct packed {
    logic       [NR_WRITE_PORTS-1:0] we;
    logic       [NR_WRITE_PORTS-1:0] wrand;
    vreg_addr_t [NR_WRITE_PORTS-1:0] waddr;
    vreg_data_t [NR_WRITE_PORTS-1:0] wdata;
    vreg_be_t   [NR_WRITE_PORTS-1:0] wbe;
    logic       [NR_READ_PORTS-1:0]  re;
    vreg_addr_t [NR_READ_PORTS-1:0]  raddr;
  } stim_t;

  logic clk = 1'b0;
  logic rst_ni;

  vreg_addr_t [NR_WRITE_PORTS-1:0] waddr;
  vreg_data_t [NR_WRITE_PORTS-1:0] wdata;
  logic       [NR_WRITE_PORTS-1:0] we;
  vreg_be_t   [NR_WRITE_PORTS-1:0] wbe;
  logic       [NR_WRITE_PORTS-1:0] wvalid;
  vreg_addr_t [NR_READ_PORTS-1:0]  raddr;
  logic       [NR_READ_PORTS-1:0]  re;
  vreg_data_t [NR_READ_PORTS-1:0]  rdata;
  logic       [NR_READ_PORTS-1:0]  rvalid;

  stim_t      stim_q[$];
  vreg_data_t model_mem[NR_ROWS];
  stim_t      pending;
  int         err_cnt   = 0;
  int         check_cnt = 0;
  int         cycle_cnt = 0;

  always #4 clk = ~clk;

  vector_regfile dut (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .waddr_i (waddr),
    .wdata_i (wdata),
    .we_i    (we),
    .wbe_i   (wbe),
    .wvalid_o(wvalid),
    .raddr_i (raddr),
    .re_i    (re),
    .rdata_o (rdata),
    .rvalid_o(rvalid)
  );

  function automatic stim_t make_stim(
    input logic [1:0] we_v, input logic [1:0] wrand_v,
    input vreg_addr_t wa0, input vreg_data_t wd0, input vreg_be_t be0,
    input vreg_addr_t wa1, input vreg_data_t wd1, input vreg_be_t be1,
    input logic [2:0] re_v, input vreg_addr_t ra0, input vreg_addr_t ra1,
    input vreg_addr_t ra2
  );
    stim_t s;
    s.we       = we_v;
    s.wrand    = wrand_v;
    s.waddr[0] = wa0;
    s.wdata[0] = wd0;
    s.wbe[0]   = be0;
    s.waddr[1] = wa1;
    s.wdata[1] = wd1;
    s.wbe[1]   = be1;
    s.re       = re_v;
    s.raddr[0] = ra0;
    s.raddr[1] = ra1;
    s.raddr[2] = ra2;
    return s;
  endfunction

  // Idle write ports, reads only
  function automatic stim_t read_only(
    input logic [2:0] re_v, input vreg_addr_t ra0, input vreg_addr_t ra1,
    input vreg_addr_t ra2
  );
    return make_stim(2'b00, 2'b00, '0, '0, '0, '0, '0, '0, re_v, ra0, ra1, ra2);
  endfunction

  task automatic build_table();
    // Contents right after reset
    stim_q.push_back(read_only(3'b111, 6'd0, 6'd17, 6'd63));
    stim_q.push_back(read_only(3'b010, 6'd1, 6'd32, 6'd62));
    // Full word to row 5, visible two edges later
    stim_q.push_back(make_stim(2'b01, 2'b01, 6'd5, '0, 16'hFFFF, '0, '0, '0,
                               3'b111, 6'd5, 6'd5, 6'd5));
    stim_q.push_back(read_only(3'b111, 6'd5, 6'd5, 6'd5));
    stim_q.push_back(read_only(3'b111, 6'd5, 6'd5, 6'd5));
    // Partial mask touching all four lanes
    stim_q.push_back(make_stim(2'b10, 2'b00, '0, '0, '0,
                               6'd5, 128'h11223344_55667788_99AABBCC_DDEEFF00, 16'h5A3C,
                               3'b001, 6'd5, 6'd0, 6'd0));
    stim_q.push_back(read_only(3'b111, 6'd5, 6'd5, 6'd5));
    stim_q.push_back(read_only(3'b111, 6'd5, 6'd5, 6'd5));
    // Base for row 9, then both ports on it with overlapping masks
    stim_q.push_back(make_stim(2'b01, 2'b01, 6'd9, '0, 16'hFFFF, '0, '0, '0,
                               3'b000, 6'd9, 6'd9, 6'd9));
    stim_q.push_back(make_stim(2'b11, 2'b00,
                               6'd9, 128'hAAAAAAAA_AAAAAAAA_AAAAAAAA_AAAAAAAA, 16'h0FF0,
                               6'd9, 128'h55555555_55555555_55555555_55555555, 16'h00FF,
                               3'b111, 6'd9, 6'd5, 6'd0));
    stim_q.push_back(read_only(3'b111, 6'd9, 6'd9, 6'd9));
    stim_q.push_back(read_only(3'b111, 6'd9, 6'd9, 6'd9));
    // Two rows of v10 at once, then back-to-back writes elsewhere
    stim_q.push_back(make_stim(2'b11, 2'b11, 6'd20, '0, 16'hFFFF, 6'd21, '0, 16'hFFFF,
                               3'b000, 6'd0, 6'd0, 6'd0));
    stim_q.push_back(make_stim(2'b11, 2'b11, 6'd40, '0, 16'hFFFF, 6'd63, '0, 16'hF00F,
                               3'b111, 6'd20, 6'd21, 6'd5));
    stim_q.push_back(read_only(3'b111, 6'd20, 6'd21, 6'd9));
    stim_q.push_back(read_only(3'b111, 6'd40, 6'd63, 6'd21));
    // Strobes low with byte enables set
    stim_q.push_back(make_stim(2'b00, 2'b11, 6'd20, '0, 16'hFFFF, 6'd5, '0, 16'hFFFF,
                               3'b000, 6'd20, 6'd5, 6'd9));
    stim_q.push_back(read_only(3'b000, 6'd20, 6'd5, 6'd9));
    stim_q.push_back(read_only(3'b101, 6'd20, 6'd5, 6'd40));
    // Same row written in consecutive cycles
    stim_q.push_back(make_stim(2'b01, 2'b01, 6'd33, '0, 16'hFFFF, '0, '0, '0,
                               3'b001, 6'd33, 6'd0, 6'd0));
    stim_q.push_back(make_stim(2'b01, 2'b01, 6'd33, '0, 16'h00FF, '0, '0, '0,
                               3'b001, 6'd33, 6'd0, 6'd0));
    stim_q.push_back(read_only(3'b111, 6'd33, 6'd32, 6'd33));
    stim_q.push_back(read_only(3'b111, 6'd33, 6'd32, 6'd40));
    stim_q.push_back(read_only(3'b111, 6'd63, 6'd21, 6'd33));
  endtask

  task automatic drive_inputs(input stim_t s);
    we    = s.we;
    waddr = s.waddr;
    wdata = s.wdata;
    wbe   = s.wbe;
    re    = s.re;
    raddr = s.raddr;
  endtask

  // Byte-wise commit, later ports overwrite earlier ones
  task automatic commit_write(input stim_t s);
    for (int p = 0; p < NR_WRITE_PORTS; p++) begin
      for (int b = 0; b < ROW_BYTES; b++) begin
        if (s.we[p] && s.wbe[p][b]) begin
          model_mem[s.waddr[p]][8*b +: 8] = s.wdata[p][8*b +: 8];
        end
      end
    end
  endtask

  task automatic check_value(input string name, input vreg_data_t actual,
                             input vreg_data_t expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic check_outputs(input stim_t s);
    for (int p = 0; p < NR_READ_PORTS; p++) begin
      check_value($sformatf("rdata_o[%0d]", p), rdata[p], model_mem[s.raddr[p]]);
    end
    check_value("rvalid_o", vreg_data_t'(rvalid), vreg_data_t'(s.re));
    check_value("wvalid_o", vreg_data_t'(wvalid), vreg_data_t'(s.we));
  endtask

  // Limit follows the table length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (stim_q.size() != 0 && cycle_cnt > stim_q.size() + RESET_CYCLES + 20) begin
      $display("Timeout after %0d cycles, the stimulus table did not finish", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    stim_t cur;
    void'($urandom(19));
    rst_ni  = 1'b0;
    pending = '0;
    drive_inputs('0);
    for (int r = 0; r < NR_ROWS; r++) begin
      model_mem[r] = '0;
    end
    build_table();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;

    for (int i = 0; i < stim_q.size(); i++) begin
      cur = stim_q[i];
      for (int p = 0; p < NR_WRITE_PORTS; p++) begin
        if (cur.wrand[p]) begin
          cur.wdata[p] = {$urandom, $urandom, $urandom, $urandom};
        end
      end
      drive_inputs(cur);
      #1;
      check_outputs(cur);
      @(posedge clk);
      // Previous sample commits on this edge, the current one is captured
      commit_write(pending);
      pending = cur;
      @(negedge clk);
    end
    drive_inputs('0);

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_vector_regfile

/* vector_regfile.f */
design/vrf_pkg.sv
design/vrf_write_stage.sv
design/vrf_bank.sv
design/vector_regfile.sv
dv/vector_regfile_checker.sv
dv/tb_vector_regfile.sv

/* Makefile */
# Verilator build and run of the vector register file testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_regfile
FILELIST  ?= vector_regfile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?=

# Sources come straight from the file list, +incdir+ lines excluded
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILELIST)

# The log decides pass or fail
run: $(BIN)
	$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || \
		{ echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
